//--- list.f
+incdir+tb
design/lmram_pkg.sv
design/reset_sequencer.sv
design/backing_store.sv
design/port_arbiter.sv
design/ram_subsystem_top.sv
tb/ram_tb.sv

//--- run.sh
#!/bin/sh
# Build the RAM subsystem testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
   -f list.f \
   --top-module ram_tb \
   -Mdir obj_dir -o ram_tb_sim

./obj_dir/ram_tb_sim | tee sim.log

if grep -q "All tests passed" sim.log; then
   echo "Simulation PASS"
else
   echo "Simulation FAIL"
   exit 1
fi

//--- tb/ram_tb_tasks.svh
// Client port driver tasks with the shadow memory that holds the expected region contents

logic [WORD_W-1:0] sdram_shadow [int];
logic [WORD_W-1:0] vram_shadow  [int];
logic [MCR_DW-1:0] mcr_shadow   [int];   // Word a sits at offsets 2a and 2a+1, so a wraps at 512

task automatic sdram_access(input logic wr, input logic [SDRAM_AW-1:0] addr,
                            input logic [WORD_W-1:0] wdata, input int exp_cycles);
   int key;
   int n;
   key = int'(addr[OFFS_W-1:0]);            // Low 10 bits pick the word
   @(negedge clk50);
   check_equal("sdram_ready", 64'(sdram_ready), 64'd1);
   check_equal("led", 64'(led), 64'(4'b0010)); // Calibrated and idle
   sdram_write   = wr;
   sdram_addr    = addr;
   sdram_data_in = wdata;
   sdram_req     = 1'b1;
   n = 0;
   do begin
      @(negedge clk50);
      n++;
   end while (!sdram_done);
   check_equal("led", 64'(led), 64'(4'b0110)); // Busy while done pulses
   if (exp_cycles > 0)
      check_equal("sdram access cycles", 64'(n), 64'(exp_cycles));
   if (wr)
      sdram_shadow[key] = wdata;
   else
      check_equal("sdram_data_out", 64'(sdram_data_out), 64'(sdram_shadow[key]));
   done_order.push_back(C_SDRAM);
   @(negedge clk50);
   sdram_req = 1'b0;                        // Dropped in the cycle after done
endtask

task automatic vram_access(input logic wr, input logic [VRAM_AW-1:0] addr,
                           input logic [WORD_W-1:0] wdata, input int exp_cycles);
   int key;
   int n;
   key = int'(addr[OFFS_W-1:0]);
   @(negedge clk50);
   check_equal("vram_cpu_ready", 64'(vram_cpu_ready), 64'd1);
   vram_cpu_write   = wr;
   vram_cpu_addr    = addr;
   vram_cpu_data_in = wdata;
   vram_cpu_req     = 1'b1;
   n = 0;
   do begin
      @(negedge clk50);
      n++;
   end while (!vram_cpu_done);
   if (exp_cycles > 0)
      check_equal("vram_cpu access cycles", 64'(n), 64'(exp_cycles));
   if (wr)
      vram_shadow[key] = wdata;
   else
      check_equal("vram_cpu_data_out", 64'(vram_cpu_data_out), 64'(vram_shadow[key]));
   done_order.push_back(C_VRAM);
   @(negedge clk50);
   vram_cpu_req = 1'b0;
endtask

task automatic mcr_access(input logic wr, input logic [MCR_AW-1:0] addr,
                          input logic [MCR_DW-1:0] wdata, input int exp_cycles);
   int key;
   int n;
   key = int'(addr[OFFS_W-2:0]);
   @(negedge clk50);
   check_equal("mcr_ready", 64'(mcr_ready), 64'd1);
   mcr_write   = wr;
   mcr_addr    = addr;
   mcr_data_in = wdata;
   mcr_req     = 1'b1;
   n = 0;
   do begin
      @(negedge clk50);
      n++;
   end while (!mcr_done);
   if (exp_cycles > 0)
      check_equal("mcr access cycles", 64'(n), 64'(exp_cycles));
   if (wr)
      mcr_shadow[key] = wdata;
   else
      check_equal("mcr_data_out", 64'(mcr_data_out), 64'(mcr_shadow[key])); // All 49 bits
   done_order.push_back(C_MCR);
   @(negedge clk50);
   mcr_req = 1'b0;
endtask

//--- tb/ram_tb.sv
// Testbench for the RAM subsystem covering start-up, port round trips, priority and restart
`timescale 1ns/10ps

module ram_tb import lmram_pkg::*; ();

   localparam int STARTUP_CYCLES = DRAM_RESET_CYCLES + CALIB_CYCLES + 1;
   localparam int SINGLE_CYCLES  = 1 + MEM_LATENCY + 1;
   localparam int MCR_CYCLES     = SINGLE_CYCLES + 1 + MEM_LATENCY; // Second beat
   localparam int N_SDRAM        = 16;
   localparam int N_MCR          = 8;
   // Two start-ups plus about 48 single and 30 mcr accesses, with margin
   localparam int MAX_CYCLES = 5 * (2 * STARTUP_CYCLES + 48 * (SINGLE_CYCLES + 2)
                                    + 30 * (MCR_CYCLES + 2));
   localparam logic [31:0] SEED = 32'h369b_02c3;

   logic                clk50;
   logic                rst_n;
   logic                button;
   logic                mcr_req;
   logic                mcr_write;
   logic [MCR_AW-1:0]   mcr_addr;
   logic [MCR_DW-1:0]   mcr_data_in;
   logic [MCR_DW-1:0]   mcr_data_out;
   logic                mcr_ready;
   logic                mcr_done;
   logic                sdram_req;
   logic                sdram_write;
   logic [SDRAM_AW-1:0] sdram_addr;
   logic [WORD_W-1:0]   sdram_data_in;
   logic [WORD_W-1:0]   sdram_data_out;
   logic                sdram_ready;
   logic                sdram_done;
   logic                vram_cpu_req;
   logic                vram_cpu_write;
   logic [VRAM_AW-1:0]  vram_cpu_addr;
   logic [WORD_W-1:0]   vram_cpu_data_in;
   logic [WORD_W-1:0]   vram_cpu_data_out;
   logic                vram_cpu_ready;
   logic                vram_cpu_done;
   logic                sys_reset;
   logic                boot;
   logic [3:0]          led;

   int                  errors       = 0;
   int                  tests_run    = 0;
   int                  tests_failed = 0;
   int                  boot_count   = 0;
   client_t             done_order [$];       // Ports in the order their done pulsed
   logic [SDRAM_AW-1:0] sdram_addrs [$];
   logic [MCR_AW-1:0]   mcr_addrs [$];

   ram_subsystem_top u_ram_subsystem_top (.*);

   ////////////////////////////////////////
   // Clock, timeout and checks
   ////////////////////////////////////////
   initial begin
      clk50 = 1'b0;
      forever #4 clk50 = ~clk50;              // 8 ns period
   end

   initial begin
      int cycles;
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge clk50);
         cycles++;
      end
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Some tests failed");
      $finish;
   end

   always @(negedge clk50) begin
      if (rst_n && boot)
         boot_count++;
   end

   task automatic record_failure(input string msg);
      errors++;
      $display("Error at %0t ns: %s", $time, msg);
   endtask

   task automatic check_equal(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      a_value: assert (got === exp) else begin
         errors++;
         $display("Mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   a_ready_in_reset: assert property (@(posedge clk50) disable iff (!rst_n)
      sys_reset |-> !(mcr_ready || sdram_ready || vram_cpu_ready))
      else record_failure("a ready output was high while sys_reset was high");

   a_boot_at_release: assert property (@(posedge clk50) disable iff (!rst_n)
      $fell(sys_reset) |-> boot)
      else record_failure("sys_reset fell without a boot pulse");

   a_boot_single: assert property (@(posedge clk50) disable iff (!rst_n)
      boot |-> !sys_reset ##1 !boot)
      else record_failure("boot was longer than one cycle or overlapped sys_reset");

   `include "ram_tb_tasks.svh"

   // Counts cycles from a start of the sequence to the fall of sys_reset
   task automatic measure_startup();
      int         n;
      logic [3:0] led_exp;
      n = 0;
      do begin
         @(negedge clk50);
         n++;
         a_ready_low: assert (!sys_reset || !(mcr_ready || sdram_ready || vram_cpu_ready))
            else record_failure("ready went high before sys_reset fell");
         // DRAM reset, idle arbiter, calibration and system reset phases
         led_exp = {n < DRAM_RESET_CYCLES, 1'b0,
                    n >= DRAM_RESET_CYCLES + CALIB_CYCLES, n < STARTUP_CYCLES};
         check_equal("led", 64'(led), 64'(led_exp));
      end while (sys_reset);
      check_equal("sys_reset release cycle", 64'(n), 64'(STARTUP_CYCLES));
      check_equal("boot", 64'(boot), 64'd1);
      @(negedge clk50);
      check_equal("boot", 64'(boot), 64'd0);
   endtask

   task automatic check_order();
      check_equal("done pulse count", 64'(done_order.size()), 64'd3);
      if (done_order.size() == 3) begin
         check_equal("first done port", 64'(done_order[0]), 64'(C_MCR));
         check_equal("second done port", 64'(done_order[1]), 64'(C_SDRAM));
         check_equal("third done port", 64'(done_order[2]), 64'(C_VRAM));
      end
   endtask

   task automatic end_test(input string name, input int err_before);
      tests_run++;
      if (errors == err_before) begin
         $display("Test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: FAILED with %0d errors", tests_run, name, errors - err_before);
      end
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////
   initial begin
      logic [63:0]       rnd;
      logic [OFFS_W-1:0] low;
      int                err0;
      void'($urandom(SEED));
      rst_n            = 1'b0;
      button           = 1'b0;
      mcr_req          = 1'b0;
      mcr_write        = 1'b0;
      mcr_addr         = '0;
      mcr_data_in      = '0;
      sdram_req        = 1'b0;
      sdram_write      = 1'b0;
      sdram_addr       = '0;
      sdram_data_in    = '0;
      vram_cpu_req     = 1'b0;
      vram_cpu_write   = 1'b0;
      vram_cpu_addr    = '0;
      vram_cpu_data_in = '0;
      repeat (2) @(negedge clk50);
      rst_n = 1'b1;

      err0 = errors;
      measure_startup();
      check_equal("boot pulse count", 64'(boot_count), 64'd1);
      end_test("start-up", err0);

      err0 = errors;
      for (int i = 0; i < N_SDRAM; i++) begin
         rnd = {$urandom, $urandom};
         sdram_addrs.push_back(rnd[SDRAM_AW-1:0]);
         sdram_access(1'b1, rnd[SDRAM_AW-1:0], rnd[63:32], SINGLE_CYCLES);
      end
      foreach (sdram_addrs[i])
         sdram_access(1'b0, sdram_addrs[i], '0, SINGLE_CYCLES);
      end_test("sdram write and read", err0);

      err0 = errors;
      for (int i = 0; i < N_MCR; i++) begin
         rnd = {$urandom, $urandom};
         mcr_addrs.push_back(rnd[63:64-MCR_AW]);
         mcr_access(1'b1, rnd[63:64-MCR_AW], rnd[MCR_DW-1:0], MCR_CYCLES);
      end
      foreach (mcr_addrs[i])
         mcr_access(1'b0, mcr_addrs[i], '0, MCR_CYCLES);
      end_test("microcode round trip", err0);

      err0 = errors;
      rnd = {$urandom, $urandom};
      low = rnd[OFFS_W-1:0];                  // Same low address on every port
      sdram_access(1'b1, SDRAM_AW'(low), $urandom, SINGLE_CYCLES);
      vram_access(1'b1, VRAM_AW'(low), $urandom, SINGLE_CYCLES);
      mcr_access(1'b1, MCR_AW'(low), rnd[MCR_DW-1:0], MCR_CYCLES);
      sdram_access(1'b0, SDRAM_AW'(low), '0, SINGLE_CYCLES);
      vram_access(1'b0, VRAM_AW'(low), '0, SINGLE_CYCLES);
      mcr_access(1'b0, MCR_AW'(low), '0, MCR_CYCLES);
      end_test("region separation", err0);

      err0 = errors;
      rnd = {$urandom, $urandom};
      done_order.delete();
      fork
         mcr_access(1'b1, rnd[MCR_AW-1:0], rnd[MCR_DW-1:0], 0);
         sdram_access(1'b1, rnd[SDRAM_AW+7:8], $urandom, 0);
         vram_access(1'b1, rnd[VRAM_AW+20:21], $urandom, 0);
      join
      check_order();
      done_order.delete();
      fork
         mcr_access(1'b0, rnd[MCR_AW-1:0], '0, 0);
         sdram_access(1'b0, rnd[SDRAM_AW+7:8], '0, 0);
         vram_access(1'b0, rnd[VRAM_AW+20:21], '0, 0);
      join
      check_order();
      end_test("fixed priority", err0);

      err0 = errors;
      @(negedge clk50);
      button = 1'b1;
      do @(negedge clk50); while (!sys_reset);
      button = 1'b0;
      measure_startup();
      check_equal("boot pulse count", 64'(boot_count), 64'd2);
      for (int i = 0; i < 4; i++)
         sdram_access(1'b0, sdram_addrs[i], '0, SINGLE_CYCLES);
      mcr_access(1'b0, mcr_addrs[0], '0, MCR_CYCLES);
      end_test("button restart", err0);

      $display("Summary: %0d tests run, %0d failed, %0d check errors",
               tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

//--- design/ram_subsystem_top.sv
// RAM subsystem top joining the start-up sequencer, port arbiter and backing store
`timescale 1ns/10ps

module ram_subsystem_top import lmram_pkg::*; (
   input  logic                clk50,
   input  logic                rst_n,
   input  logic                button,
   // Microcode port
   input  logic                mcr_req,
   input  logic                mcr_write,
   input  logic [MCR_AW-1:0]   mcr_addr,
   input  logic [MCR_DW-1:0]   mcr_data_in,
   output logic [MCR_DW-1:0]   mcr_data_out,
   output logic                mcr_ready,
   output logic                mcr_done,
   // Main memory port
   input  logic                sdram_req,
   input  logic                sdram_write,
   input  logic [SDRAM_AW-1:0] sdram_addr,
   input  logic [WORD_W-1:0]   sdram_data_in,
   output logic [WORD_W-1:0]   sdram_data_out,
   output logic                sdram_ready,
   output logic                sdram_done,
   // CPU video window port
   input  logic                vram_cpu_req,
   input  logic                vram_cpu_write,
   input  logic [VRAM_AW-1:0]  vram_cpu_addr,
   input  logic [WORD_W-1:0]   vram_cpu_data_in,
   output logic [WORD_W-1:0]   vram_cpu_data_out,
   output logic                vram_cpu_ready,
   output logic                vram_cpu_done,
   // Status
   output logic                sys_reset,
   output logic                boot,
   output logic [3:0]          led
);

   logic              dram_reset;
   logic              calib_done;
   logic              busy;
   logic              mem_req;
   logic              mem_write;
   logic [MEM_AW-1:0] mem_addr;
   logic [WORD_W-1:0] mem_wdata;
   logic [WORD_W-1:0] mem_rdata;
   logic              mem_done;

   ////////////////////////////////////////
   // Start-up and memory
   ////////////////////////////////////////
   reset_sequencer u_reset_sequencer (
      .clk50      (clk50),
      .rst_n      (rst_n),
      .button     (button),
      .calib_done (calib_done),
      .dram_reset (dram_reset),
      .sys_reset  (sys_reset),
      .boot       (boot)
   );

   port_arbiter u_port_arbiter (
      .clk50             (clk50),
      .rst_n             (rst_n),
      .sys_reset         (sys_reset),
      .calib_done        (calib_done),
      .mcr_req           (mcr_req),
      .mcr_write         (mcr_write),
      .mcr_addr          (mcr_addr),
      .mcr_data_in       (mcr_data_in),
      .mcr_data_out      (mcr_data_out),
      .mcr_ready         (mcr_ready),
      .mcr_done          (mcr_done),
      .sdram_req         (sdram_req),
      .sdram_write       (sdram_write),
      .sdram_addr        (sdram_addr),
      .sdram_data_in     (sdram_data_in),
      .sdram_data_out    (sdram_data_out),
      .sdram_ready       (sdram_ready),
      .sdram_done        (sdram_done),
      .vram_cpu_req      (vram_cpu_req),
      .vram_cpu_write    (vram_cpu_write),
      .vram_cpu_addr     (vram_cpu_addr),
      .vram_cpu_data_in  (vram_cpu_data_in),
      .vram_cpu_data_out (vram_cpu_data_out),
      .vram_cpu_ready    (vram_cpu_ready),
      .vram_cpu_done     (vram_cpu_done),
      .mem_req           (mem_req),
      .mem_write         (mem_write),
      .mem_addr          (mem_addr),
      .mem_wdata         (mem_wdata),
      .mem_rdata         (mem_rdata),
      .mem_done          (mem_done),
      .busy              (busy)
   );

   backing_store u_backing_store (
      .clk50      (clk50),
      .rst_n      (rst_n),
      .dram_reset (dram_reset),
      .mem_req    (mem_req),
      .mem_write  (mem_write),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_rdata  (mem_rdata),
      .mem_done   (mem_done),
      .calib_done (calib_done)
   );

   // Board status LEDs
   assign led = {dram_reset, busy, calib_done, sys_reset};

endmodule

//--- design/port_arbiter.sv
// Fixed-priority arbiter for the mcr, sdram and vram_cpu ports onto one memory path
`timescale 1ns/10ps

module port_arbiter import lmram_pkg::*; (
   input  logic                clk50,
   input  logic                rst_n,
   input  logic                sys_reset,
   input  logic                calib_done,
   // Microcode port
   input  logic                mcr_req,
   input  logic                mcr_write,
   input  logic [MCR_AW-1:0]   mcr_addr,
   input  logic [MCR_DW-1:0]   mcr_data_in,
   output logic [MCR_DW-1:0]   mcr_data_out,
   output logic                mcr_ready,
   output logic                mcr_done,
   // Main memory port
   input  logic                sdram_req,
   input  logic                sdram_write,
   input  logic [SDRAM_AW-1:0] sdram_addr,
   input  logic [WORD_W-1:0]   sdram_data_in,
   output logic [WORD_W-1:0]   sdram_data_out,
   output logic                sdram_ready,
   output logic                sdram_done,
   // CPU video window port
   input  logic                vram_cpu_req,
   input  logic                vram_cpu_write,
   input  logic [VRAM_AW-1:0]  vram_cpu_addr,
   input  logic [WORD_W-1:0]   vram_cpu_data_in,
   output logic [WORD_W-1:0]   vram_cpu_data_out,
   output logic                vram_cpu_ready,
   output logic                vram_cpu_done,
   // Backing store side
   output logic                mem_req,
   output logic                mem_write,
   output logic [MEM_AW-1:0]   mem_addr,
   output logic [WORD_W-1:0]   mem_wdata,
   input  logic [WORD_W-1:0]   mem_rdata,
   input  logic                mem_done,
   output logic                busy
);

   arb_state_t          state;
   client_t             cur;
   logic                beat;            // High on the second mcr beat
   logic                idle_ok;
   logic [REGION_W-1:0] region;
   logic [OFFS_W-1:0]   offset;
   logic [WORD_W-1:0]   lo_q;
   logic [WORD_W-1:0]   rd_q;

   assign idle_ok        = (state == A_IDLE) && !sys_reset && calib_done;
   assign mcr_ready      = idle_ok;
   assign sdram_ready    = idle_ok;
   assign vram_cpu_ready = idle_ok;
   assign busy           = (state != A_IDLE);

   ////////////////////////////////////////
   // Address and write data mapping
   ////////////////////////////////////////
   always_comb begin
      case (cur)
         C_MCR: begin
            region    = REGION_MCR;
            offset    = {mcr_addr[OFFS_W-2:0], beat}; // Word a at 2a, 2a+1
            mem_write = mcr_write;
            mem_wdata = beat ? WORD_W'(mcr_data_in[MCR_DW-1:WORD_W])
                             : mcr_data_in[WORD_W-1:0];
         end
         C_SDRAM: begin
            region    = REGION_SDRAM;
            offset    = sdram_addr[OFFS_W-1:0];
            mem_write = sdram_write;
            mem_wdata = sdram_data_in;
         end
         C_VRAM: begin
            region    = REGION_VRAM;
            offset    = vram_cpu_addr[OFFS_W-1:0];
            mem_write = vram_cpu_write;
            mem_wdata = vram_cpu_data_in;
         end
         default: begin
            region    = '0;
            offset    = '0;
            mem_write = 1'b0;
            mem_wdata = '0;
         end
      endcase
   end

   assign mem_addr = {region, offset};
   assign mem_req  = (state == A_ISSUE) || (state == A_BEAT2);

   ////////////////////////////////////////
   // Arbiter FSM
   ////////////////////////////////////////
   always_ff @(posedge clk50 or negedge rst_n) begin
      if (!rst_n) begin
         state <= A_IDLE;
         cur   <= C_NONE;
         beat  <= 1'b0;
      end else if (sys_reset) begin
         state <= A_IDLE;                 // Held requests restart after boot
         cur   <= C_NONE;
         beat  <= 1'b0;
      end else begin
         case (state)
            A_IDLE: begin
               beat <= 1'b0;
               if (calib_done) begin
                  if (mcr_req) begin      // Fixed priority
                     cur   <= C_MCR;
                     state <= A_ISSUE;
                  end else if (sdram_req) begin
                     cur   <= C_SDRAM;
                     state <= A_ISSUE;
                  end else if (vram_cpu_req) begin
                     cur   <= C_VRAM;
                     state <= A_ISSUE;
                  end
               end
            end
            A_ISSUE: state <= A_WAIT;
            A_WAIT: begin
               if (mem_done) begin
                  if (cur == C_MCR && !beat) begin
                     beat  <= 1'b1;
                     state <= A_BEAT2;
                  end else begin
                     state <= A_DONE;
                  end
               end
            end
            A_BEAT2: state <= A_WAIT;
            A_DONE: begin
               state <= A_IDLE;
               cur   <= C_NONE;
            end
            default: state <= A_IDLE;
         endcase
      end
   end

   // Read data capture
   always_ff @(posedge clk50) begin
      if (state == A_WAIT && mem_done) begin
         if (cur == C_MCR && !beat)
            lo_q <= mem_rdata;
         else
            rd_q <= mem_rdata;
      end
   end

   assign mcr_done          = (state == A_DONE) && (cur == C_MCR);
   assign sdram_done        = (state == A_DONE) && (cur == C_SDRAM);
   assign vram_cpu_done     = (state == A_DONE) && (cur == C_VRAM);
   assign mcr_data_out      = {rd_q[MCR_DW-WORD_W-1:0], lo_q};
   assign sdram_data_out    = rd_q;
   assign vram_cpu_data_out = rd_q;

   a_done_onehot: assert property (@(posedge clk50) disable iff (!rst_n)
      $onehot0({mcr_done, sdram_done, vram_cpu_done}));

   // A port only sees done while it still holds its request
   a_done_with_req: assert property (@(posedge clk50) disable iff (!rst_n)
      !(mcr_done && !mcr_req) && !(sdram_done && !sdram_req)
      && !(vram_cpu_done && !vram_cpu_req));

endmodule

//--- design/backing_store.sv
// Behavioral LPDDR stand-in with calibration delay and fixed two-cycle access latency
`timescale 1ns/10ps

module backing_store import lmram_pkg::*; (
   input  logic              clk50,
   input  logic              rst_n,
   input  logic              dram_reset,
   input  logic              mem_req,
   input  logic              mem_write,
   input  logic [MEM_AW-1:0] mem_addr,
   input  logic [WORD_W-1:0] mem_wdata,
   output logic [WORD_W-1:0] mem_rdata,
   output logic              mem_done,
   output logic              calib_done
);

   logic [WORD_W-1:0]      mem [0:2**MEM_AW-1];
   logic                   p1_valid;
   logic                   p1_write;
   logic [MEM_AW-1:0]      p1_addr;
   logic [WORD_W-1:0]      p1_wdata;
   logic                   p2_valid;
   logic [WORD_W-1:0]      p2_rdata;
   logic [CALIB_CNT_W-1:0] calib_cnt;

   ////////////////////////////////////////
   // Calibration
   ////////////////////////////////////////
   always_ff @(posedge clk50 or negedge rst_n) begin
      if (!rst_n) begin
         calib_cnt  <= '0;
         calib_done <= 1'b0;
      end else if (dram_reset) begin
         calib_cnt  <= '0;                // Start over on every DRAM reset
         calib_done <= 1'b0;
      end else if (!calib_done) begin
         if (calib_cnt == CALIB_CNT_W'(CALIB_CYCLES - 1))
            calib_done <= 1'b1;
         else
            calib_cnt <= calib_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////
   // Access pipeline
   ////////////////////////////////////////
   always_ff @(posedge clk50 or negedge rst_n) begin
      if (!rst_n) begin
         p1_valid <= 1'b0;
         p2_valid <= 1'b0;
      end else begin
         p1_valid <= mem_req;
         p2_valid <= p1_valid;
      end
   end

   always_ff @(posedge clk50) begin
      if (mem_req) begin
         p1_write <= mem_write;           // Stage 1 holds the command
         p1_addr  <= mem_addr;
         p1_wdata <= mem_wdata;
      end
      if (p1_valid) begin
         if (p1_write)
            mem[p1_addr] <= p1_wdata;
         p2_rdata <= mem[p1_addr];        // Old word on a write
      end
   end

   assign mem_rdata = p2_rdata;
   assign mem_done  = p2_valid;

   // One access at a time, and only once calibrated
   a_req_legal: assert property (@(posedge clk50) disable iff (!rst_n)
      mem_req |-> calib_done && !p1_valid && !p2_valid);

endmodule

//--- design/reset_sequencer.sv
// Reset sequencer that steps DRAM reset, calibration wait and boot from a push button
`timescale 1ns/10ps

module reset_sequencer import lmram_pkg::*; (
   input  logic clk50,
   input  logic rst_n,
   input  logic button,
   input  logic calib_done,
   output logic dram_reset,
   output logic sys_reset,
   output logic boot
);

   logic                 btn_meta;
   logic                 btn_sync;
   logic                 btn_last;
   logic                 restart;
   seq_state_t           state;
   logic [SEQ_CNT_W-1:0] cnt;

   ////////////////////////////////////////
   // Button synchronizer and edge detect
   ////////////////////////////////////////
   always_ff @(posedge clk50 or negedge rst_n) begin
      if (!rst_n) begin
         btn_meta <= 1'b0;
         btn_sync <= 1'b0;
         btn_last <= 1'b0;
      end else begin
         btn_meta <= button;
         btn_sync <= btn_meta;
         btn_last <= btn_sync;
      end
   end

   assign restart = btn_sync & ~btn_last; // Rising edge only

   ////////////////////////////////////////
   // Sequence FSM
   ////////////////////////////////////////
   always_ff @(posedge clk50 or negedge rst_n) begin
      if (!rst_n) begin
         state <= S_DRAM_RST;
         cnt   <= '0;
      end else if (restart) begin
         state <= S_DRAM_RST;             // Memory contents survive
         cnt   <= '0;
      end else begin
         case (state)
            S_DRAM_RST: begin
               if (cnt == SEQ_CNT_W'(DRAM_RESET_CYCLES - 1)) begin
                  state <= S_CALIB;
                  cnt   <= '0;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            S_CALIB:  if (calib_done) state <= S_BOOT;
            S_BOOT:   state <= S_RUN;     // Single boot cycle
            S_RUN:    state <= S_RUN;
            default:  state <= S_DRAM_RST;
         endcase
      end
   end

   assign dram_reset = (state == S_DRAM_RST);
   assign sys_reset  = (state == S_DRAM_RST) || (state == S_CALIB);
   assign boot       = (state == S_BOOT);

   // Boot is a single pulse, and only with the memory calibrated
   a_boot_pulse: assert property (@(posedge clk50) disable iff (!rst_n)
      boot |-> calib_done ##1 !boot);

endmodule

//--- design/lmram_pkg.sv
// LM RAM subsystem shared widths, region tags, timing constants and state types
package lmram_pkg;

   ////////////////////////////////////////
   // Client port widths
   ////////////////////////////////////////
   localparam int MCR_AW   = 14;         // Microcode address
   localparam int MCR_DW   = 49;         // Microcode word
   localparam int SDRAM_AW = 22;         // Main memory address
   localparam int VRAM_AW  = 15;         // CPU video window address
   localparam int WORD_W   = 32;         // Memory word

   ////////////////////////////////////////
   // Backing store layout
   ////////////////////////////////////////
   localparam int MEM_AW   = 12;         // Region tag plus offset
   localparam int REGION_W = 2;
   localparam int OFFS_W   = MEM_AW - REGION_W;

   localparam logic [REGION_W-1:0] REGION_MCR   = 2'd0;
   localparam logic [REGION_W-1:0] REGION_SDRAM = 2'd1;
   localparam logic [REGION_W-1:0] REGION_VRAM  = 2'd2;

   ////////////////////////////////////////
   // Timing
   ////////////////////////////////////////
   localparam int CALIB_CYCLES      = 16; // dram_reset low to calib_done
   localparam int DRAM_RESET_CYCLES = 4;  // Length of dram_reset
   localparam int MEM_LATENCY       = 2;  // mem_req to mem_done
   localparam int SEQ_CNT_W         = 3;  // Holds DRAM_RESET_CYCLES-1
   localparam int CALIB_CNT_W       = 5;  // Holds CALIB_CYCLES-1

   // Start-up sequencer
   typedef enum logic [1:0] {
      S_DRAM_RST,
      S_CALIB,
      S_BOOT,
      S_RUN
   } seq_state_t;

   // Port arbiter
   typedef enum logic [2:0] {
      A_IDLE,
      A_ISSUE,
      A_WAIT,
      A_BEAT2,
      A_DONE
   } arb_state_t;

   typedef enum logic [1:0] {
      C_NONE,
      C_MCR,
      C_SDRAM,
      C_VRAM
   } client_t;

endpackage
